// File: flstory_comm.f
+incdir+source
source/flstory_pkg.sv
source/flstory_if.sv
source/flstory_header.sv
source/flstory_mailbox.sv
source/flstory_bus_ctrl.sv
source/flstory_comm.sv
testbench/tb_flstory_comm.sv

// File: testbench/tb_flstory_comm.sv
/* table-driven testbench for the board glue top covering header decode, both mailboxes, window and coins
   each row drives one strobe, checks read data mid-cycle and the flags two edges later */
`timescale 1ns/10ps
`default_nettype none

`include "flstory_settings.svh"

module tb_flstory_comm import flstory_pkg::*; ();

    localparam int    RST_CYCLES = 16;
    localparam addr_t W0 = `FLS_IO_BASE0;
    localparam addr_t W1 = `FLS_IO_BASE1;

    typedef enum logic [2:0] {OP_HDR, OP_BWR, OP_BRD, OP_PWR, OP_PRD, OP_COIN} op_e;

    // exp_st holds snd_ibf, snd_obf, mcu_ibf, mcu_obf
    typedef struct packed {
        op_e        op;
        io_reg_e    id;
        addr_t      addr;
        byte_t      data;
        byte_t      exp_byte;
        logic [3:0] exp_st;
        hdr_flags_t exp_hdr;
    } row_t;

    logic        clk, rst, header, prog_we, bus_wr, bus_rd, service;
    logic [2:0]  prog_addr;
    logic [1:0]  coin;
    logic [15:0] dipsw;
    addr_t       bus_addr;
    byte_t       prog_data, bus_dout, bus_din;
    logic        snd_wr, snd_rd, snd_ibf, snd_obf;
    logic        mcu_wr, mcu_rd, mcu_ibf, mcu_obf, mcu_rst;
    byte_t       snd_wdata, snd_rdata, mcu_wdata, mcu_rdata;
    hdr_flags_t  hdr_flags;
    row_t        rows[$];
    int          cur_row;

    flstory_comm dut_i (.*);

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("ERROR %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flags(input string name, input hdr_flags_t got, input hdr_flags_t exp);
        if (got !== exp) begin
            $display("ERROR %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s row %0d: got %h, expected %h", name, cur_row, got, exp);
            stop_run();
        end
    endtask

    task automatic add_row(input op_e op, input io_reg_e id, input addr_t addr, input byte_t data,
                           input byte_t eb, input logic [3:0] st, input hdr_flags_t hx);
        rows.push_back('{op, id, addr, data, eb, st, hx});
    endtask

    task automatic idle_strobes();
        header  = 1'b0;
        prog_we = 1'b0;
        bus_wr  = 1'b0;
        bus_rd  = 1'b0;
        snd_wr  = 1'b0;
        snd_rd  = 1'b0;
        mcu_wr  = 1'b0;
        mcu_rd  = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        #1;
        header    = (r.op == OP_HDR);
        prog_we   = (r.op == OP_HDR);
        prog_addr = r.addr[2:0];
        prog_data = r.data;
        bus_addr  = r.addr;
        bus_dout  = r.data;
        bus_wr    = (r.op == OP_BWR);
        bus_rd    = (r.op == OP_BRD);
        snd_wr    = (r.op == OP_PWR) && (r.id == IO_SND);
        snd_rd    = (r.op == OP_PRD) && (r.id == IO_SND);
        mcu_wr    = (r.op == OP_PWR) && (r.id == IO_MCU);
        mcu_rd    = (r.op == OP_PRD) && (r.id == IO_MCU);
        snd_wdata = r.data;
        mcu_wdata = r.data;
        if (r.op == OP_COIN) begin
            coin    = r.data[1:0];
            service = r.data[2];
        end
        // read data is combinational, sampled while the strobe is still up
        @(negedge clk);
        if (r.op == OP_BRD) begin
            check_byte("bus_din", bus_din, r.exp_byte);
        end else if (snd_rd) begin
            check_byte("snd_rdata", snd_rdata, r.exp_byte);
        end else if (mcu_rd) begin
            check_byte("mcu_rdata", mcu_rdata, r.exp_byte);
        end
        @(posedge clk);
        #1;
        idle_strobes();
        // second edge so mcu_rst has followed a header change
        @(posedge clk);
        @(negedge clk);
        check_bit("snd_ibf", snd_ibf, r.exp_st[3]);
        check_bit("snd_obf", snd_obf, r.exp_st[2]);
        check_bit("mcu_ibf", mcu_ibf, r.exp_st[1]);
        check_bit("mcu_obf", mcu_obf, r.exp_st[0]);
        check_bit("mcu_rst", mcu_rst, r.exp_hdr[`FLS_BIT_MCU_ENB]);
        check_flags("hdr_flags", hdr_flags, r.exp_hdr);
    endtask

    task automatic build_table();
        byte_t      hs, hs2, ps, hm, pm, ce1, ce2;
        logic [2:0] c1, c2;
        hs  = byte_t'($urandom);
        hs2 = ~hs;
        ps  = byte_t'($urandom);
        hm  = byte_t'($urandom);
        pm  = byte_t'($urandom);
        c1  = 3'($urandom);
        c2  = 3'($urandom);
        // coins inverted for c1, straight for c2, service in bit 2
        ce1 = {5'b11111, c1[2], c1[1:0] ^ 2'b11};
        ce2 = {5'b11111, c2};
        // header bytes, MCU marked absent, bytes past the header ignored
        add_row(OP_HDR, IO_NONE, 16'd0, 8'h04, 8'h00, 4'b0000, 16'h0004);
        add_row(OP_HDR, IO_NONE, 16'd1, 8'h5a, 8'h00, 4'b0000, 16'h5a04);
        add_row(OP_HDR, IO_NONE, 16'd2, 8'hff, 8'h00, 4'b0000, 16'h5a04);
        add_row(OP_HDR, IO_NONE, 16'd6, 8'h81, 8'h00, 4'b0000, 16'h5a04);
        // held MCU drops both directions
        add_row(OP_BWR, IO_MCU, W0 + `FLS_REG_MCU, ~hm, 8'h00, 4'b0000, 16'h5a04);
        add_row(OP_PWR, IO_MCU, 16'd0, ~pm, 8'h00, 4'b0000, 16'h5a04);
        // MCU present, coin inversion on
        add_row(OP_HDR, IO_NONE, 16'd0, 8'h08, 8'h00, 4'b0000, 16'h5a08);
        // sound mailbox round trip
        add_row(OP_BWR, IO_SND, W0 + `FLS_REG_SND, hs, 8'h00, 4'b1000, 16'h5a08);
        add_row(OP_BRD, IO_STAT, W0 + `FLS_REG_STAT, 8'h00, 8'h08, 4'b1000, 16'h5a08);
        add_row(OP_PRD, IO_SND, 16'd0, 8'h00, hs, 4'b0000, 16'h5a08);
        add_row(OP_PWR, IO_SND, 16'd0, ps, 8'h00, 4'b0100, 16'h5a08);
        add_row(OP_BRD, IO_STAT, W0 + `FLS_REG_STAT, 8'h00, 8'h04, 4'b0100, 16'h5a08);
        add_row(OP_BRD, IO_SND, W0 + `FLS_REG_SND, 8'h00, ps, 4'b0000, 16'h5a08);
        // no back-pressure, second byte replaces the first
        add_row(OP_BWR, IO_SND, W0 + `FLS_REG_SND, hs, 8'h00, 4'b1000, 16'h5a08);
        add_row(OP_BWR, IO_SND, W0 + `FLS_REG_SND, hs2, 8'h00, 4'b1000, 16'h5a08);
        add_row(OP_PRD, IO_SND, 16'd0, 8'h00, hs2, 4'b0000, 16'h5a08);
        // MCU mailbox, same steps
        add_row(OP_BWR, IO_MCU, W0 + `FLS_REG_MCU, hm, 8'h00, 4'b0010, 16'h5a08);
        add_row(OP_BRD, IO_STAT, W0 + `FLS_REG_STAT, 8'h00, 8'h02, 4'b0010, 16'h5a08);
        add_row(OP_PRD, IO_MCU, 16'd0, 8'h00, hm, 4'b0000, 16'h5a08);
        add_row(OP_PWR, IO_MCU, 16'd0, pm, 8'h00, 4'b0001, 16'h5a08);
        add_row(OP_BRD, IO_STAT, W0 + `FLS_REG_STAT, 8'h00, 8'h01, 4'b0001, 16'h5a08);
        add_row(OP_BRD, IO_MCU, W0 + `FLS_REG_MCU, 8'h00, pm, 4'b0000, 16'h5a08);
        // window at D000 while iocfg is low
        add_row(OP_BRD, IO_NONE, W1 + `FLS_REG_DIPL, 8'h00, 8'hff, 4'b0000, 16'h5a08);
        add_row(OP_BRD, IO_DIPL, W0 + `FLS_REG_DIPL, 8'h00, dipsw[7:0], 4'b0000, 16'h5a08);
        add_row(OP_BRD, IO_DIPH, W0 + `FLS_REG_DIPH, 8'h00, dipsw[15:8], 4'b0000, 16'h5a08);
        add_row(OP_BRD, IO_NONE, W0 + 16'd6, 8'h00, 8'hff, 4'b0000, 16'h5a08);
        add_row(OP_COIN, IO_COIN, 16'd0, {5'd0, c1}, 8'h00, 4'b0000, 16'h5a08);
        add_row(OP_BRD, IO_COIN, W0 + `FLS_REG_COIN, 8'h00, ce1, 4'b0000, 16'h5a08);
        // iocfg high moves the window to C800, then inversion off
        add_row(OP_HDR, IO_NONE, 16'd1, 8'hda, 8'h00, 4'b0000, 16'hda08);
        add_row(OP_HDR, IO_NONE, 16'd0, 8'h00, 8'h00, 4'b0000, 16'hda00);
        add_row(OP_BRD, IO_NONE, W0 + `FLS_REG_DIPL, 8'h00, 8'hff, 4'b0000, 16'hda00);
        add_row(OP_BRD, IO_DIPL, W1 + `FLS_REG_DIPL, 8'h00, dipsw[7:0], 4'b0000, 16'hda00);
        add_row(OP_COIN, IO_COIN, 16'd0, {5'd0, c2}, 8'h00, 4'b0000, 16'hda00);
        add_row(OP_BRD, IO_COIN, W1 + `FLS_REG_COIN, 8'h00, ce2, 4'b0000, 16'hda00);
    endtask

    task automatic watchdog(input int limit);
        repeat (limit) @(posedge clk);
        $display("timeout: the table did not finish within %0d clock cycles", limit);
        stop_run();
    endtask

    initial begin
        void'($urandom(32'h6270_03b0));
        clk       = 1'b0;
        rst       = 1'b1;
        prog_addr = 3'd0;
        prog_data = 8'h00;
        bus_addr  = 16'h0000;
        bus_dout  = 8'h00;
        coin      = 2'b00;
        service   = 1'b0;
        snd_wdata = 8'h00;
        mcu_wdata = 8'h00;
        dipsw     = 16'($urandom);
        idle_strobes();
        build_table();
        fork
            watchdog(rows.size() * 10 + RST_CYCLES);
        join_none
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i]) begin
            cur_row = i;
            apply_row(rows[i]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/flstory_comm.sv
/* board glue top with header decode, main CPU I/O window and the sound and MCU mailboxes
   peer CPUs attach through the snd_ and mcu_ ports, game flags leave on hdr_flags */
`timescale 1ns/10ps
`default_nettype none

module flstory_comm import flstory_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    // ROM download
    input  wire logic        header,
    input  wire logic        prog_we,
    input  wire logic [2:0]  prog_addr,
    input  wire byte_t       prog_data,
    // main CPU bus
    input  wire addr_t       bus_addr,
    input  wire logic        bus_wr,
    input  wire logic        bus_rd,
    input  wire byte_t       bus_dout,
    output byte_t            bus_din,
    // cabinet
    input  wire logic [1:0]  coin,
    input  wire logic        service,
    input  wire logic [15:0] dipsw,
    // sound CPU side
    input  wire logic        snd_wr,
    input  wire logic        snd_rd,
    input  wire byte_t       snd_wdata,
    output byte_t            snd_rdata,
    output logic             snd_ibf,
    output logic             snd_obf,
    // MCU side
    input  wire logic        mcu_wr,
    input  wire logic        mcu_rd,
    input  wire byte_t       mcu_wdata,
    output byte_t            mcu_rdata,
    output logic             mcu_ibf,
    output logic             mcu_obf,
    output logic             mcu_rst,
    output hdr_flags_t       hdr_flags
);

    flstory_cfg_if  cfg_i ();
    flstory_mbox_if snd_i ();
    flstory_mbox_if mcu_i ();

    flstory_header u_header (
        .clk       (clk),
        .rst       (rst),
        .header    (header),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .cfg       (cfg_i.src)
    );

    flstory_bus_ctrl u_bus_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg_i.dst),
        .bus_addr (bus_addr),
        .bus_wr   (bus_wr),
        .bus_rd   (bus_rd),
        .bus_dout (bus_dout),
        .bus_din  (bus_din),
        .coin     (coin),
        .service  (service),
        .dipsw    (dipsw),
        .mcu      (mcu_i.host),
        .snd      (snd_i.host)
    );

    // MCU stays in reset while the header marks it absent
    always_ff @(posedge clk) begin
        if (rst) begin
            mcu_rst <= 1'b1;
        end else begin
            mcu_rst <= cfg_i.mcu_enb;
        end
    end

    flstory_mailbox u_snd_mbox (
        .clk        (clk),
        .rst        (rst),
        .host       (snd_i.box),
        .peer_wr    (snd_wr),
        .peer_rd    (snd_rd),
        .peer_wdata (snd_wdata),
        .peer_rdata (snd_rdata)
    );

    flstory_mailbox u_mcu_mbox (
        .clk        (clk),
        .rst        (mcu_rst),
        .host       (mcu_i.box),
        .peer_wr    (mcu_wr),
        .peer_rd    (mcu_rd),
        .peer_wdata (mcu_wdata),
        .peer_rdata (mcu_rdata)
    );

    assign snd_ibf   = snd_i.ibf;
    assign snd_obf   = snd_i.obf;
    assign mcu_ibf   = mcu_i.ibf;
    assign mcu_obf   = mcu_i.obf;
    assign hdr_flags = cfg_i.flags;

endmodule

`default_nettype wire

// File: source/flstory_bus_ctrl.sv
/* main CPU I/O window: address decode, mailbox strobes, coin conditioning and read mux
   bus strobes last one cycle with address and data valid alongside */
`timescale 1ns/10ps
`default_nettype none

`include "flstory_settings.svh"

module flstory_bus_ctrl import flstory_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    flstory_cfg_if.dst       cfg,
    input  wire addr_t       bus_addr,
    input  wire logic        bus_wr,
    input  wire logic        bus_rd,
    input  wire byte_t       bus_dout,
    output byte_t            bus_din,
    input  wire logic [1:0]  coin,
    input  wire logic        service,
    input  wire logic [15:0] dipsw,
    flstory_mbox_if.host     mcu,
    flstory_mbox_if.host     snd
);

    localparam addr_t BASE0 = `FLS_IO_BASE0;
    localparam addr_t BASE1 = `FLS_IO_BASE1;
    localparam int    WB    = `FLS_IO_WIN_BITS;

    addr_t       base_sel;
    logic        in_win;
    logic [WB-1:0] offset;
    io_reg_e     reg_sel;
    logic [1:0]  coin_eff;

    // window base follows the iocfg header flag
    assign base_sel = cfg.iocfg ? BASE1 : BASE0;
    assign in_win   = bus_addr[15:WB] == base_sel[15:WB];
    assign offset   = bus_addr[WB-1:0];

    always_comb begin
        reg_sel = IO_NONE;
        if (in_win) begin
            case (offset)
                `FLS_REG_MCU:  reg_sel = IO_MCU;
                `FLS_REG_SND:  reg_sel = IO_SND;
                `FLS_REG_STAT: reg_sel = IO_STAT;
                `FLS_REG_COIN: reg_sel = IO_COIN;
                `FLS_REG_DIPL: reg_sel = IO_DIPL;
                `FLS_REG_DIPH: reg_sel = IO_DIPH;
                default:       reg_sel = IO_NONE;
            endcase
        end
    end

    // mailbox strobes
    assign mcu.h_wr    = bus_wr && (reg_sel == IO_MCU);
    assign mcu.h_rd    = bus_rd && (reg_sel == IO_MCU);
    assign mcu.h_wdata = bus_dout;
    assign snd.h_wr    = bus_wr && (reg_sel == IO_SND);
    assign snd.h_rd    = bus_rd && (reg_sel == IO_SND);
    assign snd.h_wdata = bus_dout;

    // some boards wire the coin switches inverted
    always_ff @(posedge clk) begin
        if (rst) begin
            coin_eff <= 2'b00;
        end else begin
            coin_eff <= coin ^ {2{cfg.coinxor}};
        end
    end

    // read data, FF for anything unmapped
    always_comb begin
        case (reg_sel)
            IO_MCU:  bus_din = mcu.h_rdata;
            IO_SND:  bus_din = snd.h_rdata;
            IO_STAT: bus_din = {4'h0, snd.ibf, snd.obf, mcu.ibf, mcu.obf};
            IO_COIN: bus_din = {5'b11111, service, coin_eff};
            IO_DIPL: bus_din = dipsw[7:0];
            IO_DIPH: bus_din = dipsw[15:8];
            default: bus_din = 8'hff;
        endcase
    end

    a_no_wr_rd: assert property (
        @(posedge clk) disable iff (rst)
        !(bus_wr && bus_rd)
    );

endmodule

`default_nettype wire

// File: source/flstory_mailbox.sv
/* one-byte bidirectional mailbox between the main CPU and a peer CPU
   ibf flags a byte for the peer, obf flags a byte for the main CPU, both polled by software */
`timescale 1ns/10ps
`default_nettype none

module flstory_mailbox import flstory_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    flstory_mbox_if.box host,
    input  wire logic   peer_wr,
    input  wire logic   peer_rd,
    input  wire byte_t  peer_wdata,
    output byte_t       peer_rdata
);

    // main to peer
    byte_t m2p;
    // peer to main
    byte_t p2m;
    logic  ibf;
    logic  obf;

    // data latches, overwritten on every write
    always_ff @(posedge clk) begin
        if (host.h_wr) begin
            m2p <= host.h_wdata;
        end
        if (peer_wr) begin
            p2m <= peer_wdata;
        end
    end

    // a set in the same cycle as a clear wins
    always_ff @(posedge clk) begin
        if (rst) begin
            ibf <= 1'b0;
        end else if (host.h_wr) begin
            ibf <= 1'b1;
        end else if (peer_rd) begin
            ibf <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            obf <= 1'b0;
        end else if (peer_wr) begin
            obf <= 1'b1;
        end else if (host.h_rd) begin
            obf <= 1'b0;
        end
    end

    assign peer_rdata   = m2p;
    assign host.h_rdata = p2m;
    assign host.ibf     = ibf;
    assign host.obf     = obf;

    a_ibf_set: assert property (
        @(posedge clk) disable iff (rst)
        host.h_wr |=> ibf
    );

    a_obf_set: assert property (
        @(posedge clk) disable iff (rst)
        peer_wr |=> obf
    );

endmodule

`default_nettype wire

// File: source/flstory_header.sv
/* captures the game configuration bytes streamed during ROM download
   and presents them as flags on the configuration interface */
`timescale 1ns/10ps
`default_nettype none

`include "flstory_settings.svh"

module flstory_header import flstory_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        header,
    input  wire logic        prog_we,
    input  wire logic [2:0]  prog_addr,
    input  wire byte_t       prog_data,
    flstory_cfg_if.src       cfg
);

    hdr_flags_t flags;
    logic       hdr_we;

    // only the first bytes of the header are decoded
    assign hdr_we = header && prog_we && (prog_addr < `FLS_HDR_LEN);

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (hdr_we) begin
            // byte 1 lands in the upper half
            if (prog_addr[0]) begin
                flags[15:8] <= prog_data;
            end else begin
                flags[7:0] <= prog_data;
            end
        end
    end

    // single flags used inside the glue
    assign cfg.coinxor = flags[`FLS_BIT_COINXOR];
    assign cfg.mcu_enb = flags[`FLS_BIT_MCU_ENB];
    assign cfg.iocfg   = flags[`FLS_BIT_IOCFG];

    // whole word goes out for video, sound and the rest
    assign cfg.flags   = flags;

    // flags only move on a header write
    a_flags_hold: assert property (
        @(posedge clk) disable iff (rst)
        !hdr_we |=> $stable(cfg.flags)
    );

endmodule

`default_nettype wire

// File: source/flstory_if.sv
/* configuration and mailbox interfaces used between the blocks of the board glue
   cfg runs from the header decoder to its consumers, mbox from the bus decoder to a mailbox */
`timescale 1ns/10ps
`default_nettype none

// decoded game flags
interface flstory_cfg_if import flstory_pkg::*; ();

    logic       coinxor;
    logic       iocfg;
    logic       mcu_enb;
    hdr_flags_t flags;

    modport src (
        output coinxor,
        output iocfg,
        output mcu_enb,
        output flags
    );

    modport dst (
        input  coinxor,
        input  iocfg,
        input  mcu_enb,
        input  flags
    );

endinterface

// host side of a one-byte mailbox
interface flstory_mbox_if import flstory_pkg::*; ();

    logic  h_wr;
    logic  h_rd;
    byte_t h_wdata;
    byte_t h_rdata;
    // byte waiting for the peer
    logic  ibf;
    // byte waiting for the host
    logic  obf;

    modport host (
        output h_wr,
        output h_rd,
        output h_wdata,
        input  h_rdata,
        input  ibf,
        input  obf
    );

    modport box (
        input  h_wr,
        input  h_rd,
        input  h_wdata,
        output h_rdata,
        output ibf,
        output obf
    );

endinterface

`default_nettype wire

// File: source/flstory_pkg.sv
/* types for the arcade board glue: bytes, CPU addresses, header flags and I/O registers
   imported by the interfaces, the RTL modules and the testbench */
`default_nettype none

package flstory_pkg;

    // data byte on every CPU bus
    typedef logic [7:0] byte_t;

    // main CPU address
    typedef logic [15:0] addr_t;

    // two header bytes as one word
    // byte 0: mirror, osdflip, mcu_enb, coinxor, gfx, prio, palw, cab
    // byte 1: obj, sub, dec, banks[1:0], psg2, ramcfg, iocfg
    typedef logic [15:0] hdr_flags_t;

    // register hit by the main CPU inside the I/O window
    typedef enum logic [2:0] {
        IO_NONE,
        IO_MCU,
        IO_SND,
        IO_STAT,
        IO_COIN,
        IO_DIPL,
        IO_DIPH
    } io_reg_e;

endpackage

`default_nettype wire

// File: source/flstory_settings.svh
/* constants shared by the board glue RTL: header length, I/O window bases and offsets
   include after the package import in any module that decodes the bus or the header */
`ifndef FLSTORY_SETTINGS_SVH
`define FLSTORY_SETTINGS_SVH

// header bytes that carry game flags
`define FLS_HDR_LEN      2

// flag positions inside the 16-bit header word
`define FLS_BIT_MCU_ENB  2
`define FLS_BIT_COINXOR  3
`define FLS_BIT_IOCFG    15

// I/O window, 2 KB, base picked by iocfg
`define FLS_IO_WIN_BITS  11
`define FLS_IO_BASE0     16'hD000
`define FLS_IO_BASE1     16'hC800

// register offsets inside the window
`define FLS_REG_MCU      11'd0
`define FLS_REG_SND      11'd1
`define FLS_REG_STAT     11'd2
`define FLS_REG_COIN     11'd3
`define FLS_REG_DIPL     11'd4
`define FLS_REG_DIPH     11'd5

`endif
